/* Makefile */
# Verilator build and run of the router testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module router_core_tb -Mdir obj_dir
	./obj_dir/Vrouter_core_tb | tee $(LOG)
	@grep -qx "No errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* design/flit_register.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_register
#(
	parameter type payload_t = logic [7:0]
)
(
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	logic     full;
	payload_t data;

	// A new item fits when the slot is empty or is drained on this same edge
	assign in_ready  = !full || out_ready;
	assign out_valid = full;
	assign out_data  = data;

	always_ff @(posedge clk)
	begin
		if (reset)
			full <= 1'b0;
		else if (in_valid && in_ready)
			full <= 1'b1;
		else if (out_ready)
			full <= 1'b0;
	end

	// The payload only moves on an accepted handshake
	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			data <= in_data;
	end

	// A stalled item must not change under the receiver
	held_item_stable : assert property (@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

`default_nettype wire

/* design/noc_config.svh */
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Port codes, in the fixed priority order used by every selector
`define PE        3'd0
`define X_POS     3'd1
`define Y_POS     3'd2
`define X_NEG     3'd3
`define Y_NEG     3'd4

// Relative request bits seen from each input port
// Each input drops its own direction and keeps the remaining order
`define PE_XPOS   2'd0
`define PE_YPOS   2'd1
`define PE_XNEG   2'd2
`define PE_YNEG   2'd3

`define XPOS_PE   2'd0
`define XPOS_YPOS 2'd1
`define XPOS_XNEG 2'd2
`define XPOS_YNEG 2'd3

`define YPOS_PE   2'd0
`define YPOS_XPOS 2'd1
`define YPOS_XNEG 2'd2
`define YPOS_YNEG 2'd3

`define XNEG_PE   2'd0
`define XNEG_XPOS 2'd1
`define XNEG_YPOS 2'd2
`define XNEG_YNEG 2'd3

`define YNEG_PE   2'd0
`define YNEG_XPOS 2'd1
`define YNEG_YPOS 2'd2
`define YNEG_XNEG 2'd3

// Flit field widths
`define COORD_W   3
`define PAYLOAD_W 16

// Position of this router in the mesh
`define ROUTER_X  3
`define ROUTER_Y  3

`endif

/* design/noc_flit_pkg.sv */
`default_nettype none

`include "noc_config.svh"

package noc_flit_pkg;

	// One mesh coordinate on either axis
	typedef logic [`COORD_W-1:0] coord_t;

	// A single-flit packet
	// The destination sits in the upper bits so that routing only looks at the top
	typedef struct packed
	{
		coord_t                dest_x;
		coord_t                dest_y;
		logic [`PAYLOAD_W-1:0] payload;
	} flit_t;

endpackage

`default_nettype wire

/* design/noc_port_pkg.sv */
`default_nettype none

`include "noc_config.svh"

package noc_port_pkg;

	import noc_flit_pkg::*;

	// The five router directions, encoded with the shared port codes
	typedef enum logic [2:0]
	{
		DIR_PE   = `PE,
		DIR_XPOS = `X_POS,
		DIR_YPOS = `Y_POS,
		DIR_XNEG = `X_NEG,
		DIR_YNEG = `Y_NEG
	} port_dir_t;

	// Four request bits, one per output other than the owner's own direction
	typedef logic [3:0] req_vec_t;

	// Flit offered by a sender on an input link
	typedef struct packed
	{
		logic  valid;
		flit_t flit;
	} link_in_t;

	// Flit offered by the router on an output link
	typedef struct packed
	{
		logic  valid;
		flit_t flit;
	} link_out_t;

endpackage

`default_nettype wire

/* design/output_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module output_arbiter
	import noc_flit_pkg::*, noc_port_pkg::*;
#(
	parameter port_dir_t OUT_DIR = DIR_PE
)
(
	input  logic      clk,
	input  logic      reset,
	input  req_vec_t  request,
	output req_vec_t  grant,
	input  flit_t     flit_in,
	output link_out_t out,
	input  logic      out_ready,
	output logic      free
);

	localparam coord_t HOME_X = coord_t'(`ROUTER_X);
	localparam coord_t HOME_Y = coord_t'(`ROUTER_Y);

	logic [1:0] ptr;
	logic [1:0] win_idx;
	req_vec_t   next_grant;
	logic       reg_in_ready;
	logic       reg_valid;
	flit_t      reg_flit;
	logic       productive;

	// Round robin starting at the pointer
	// Scanning backwards leaves the request closest to the pointer as the winner
	always_comb
	begin
		logic [1:0] idx;
		next_grant = '0;
		win_idx    = ptr;
		for (int k = 3; k >= 0; k--)
		begin
			idx = ptr + 2'(k);
			if (request[idx])
			begin
				next_grant      = '0;
				next_grant[idx] = 1'b1;
				win_idx         = idx;
			end
		end
	end

	// The grant lives for one cycle only since free drops while it is pending
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			grant <= '0;
			ptr   <= '0;
		end
		else if (free && (request != '0))
		begin
			grant <= next_grant;
			ptr   <= win_idx + 2'd1;
		end
		else
			grant <= '0;
	end

	// Free means the output slot will be empty by the time a new grant loads it
	assign free = reg_in_ready && (grant == '0);

	// Output register, loaded from the crossbar during the grant cycle
	flit_register #(.payload_t(flit_t)) u_out_reg (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (grant != '0),
		.in_data   (flit_in),
		.in_ready  (reg_in_ready),
		.out_valid (reg_valid),
		.out_data  (reg_flit),
		.out_ready (out_ready)
	);

	assign out.valid = reg_valid;
	assign out.flit  = reg_flit;

	// Whether the steered flit really moves closer to its destination through this port
	always_comb
	begin
		case (OUT_DIR)
			`PE:     productive = (flit_in.dest_x == HOME_X) && (flit_in.dest_y == HOME_Y);
			`X_POS:  productive = flit_in.dest_x > HOME_X;
			`Y_POS:  productive = flit_in.dest_y > HOME_Y;
			`X_NEG:  productive = flit_in.dest_x < HOME_X;
			default: productive = flit_in.dest_y < HOME_Y;
		endcase
	end

	// One winner, and the grant is gone again on the next edge
	grant_pulse : assert property (@(posedge clk) disable iff (reset)
		(grant != '0) |-> $onehot(grant) ##1 (grant == '0));

	// The crossbar must hand over a flit that was planned for this output
	grant_productive : assert property (@(posedge clk) disable iff (reset)
		(grant != '0) |-> productive);

endmodule

`default_nettype wire

/* design/route_planner.sv */
`timescale 1ns/1ps
`default_nettype none

module route_planner
	import noc_flit_pkg::*, noc_port_pkg::*;
#(
	parameter port_dir_t PORT_DIR = DIR_XPOS
)
(
	input  logic     flit_valid,
	input  flit_t    flit,
	output req_vec_t request
);

	localparam coord_t HOME_X = coord_t'(`ROUTER_X);
	localparam coord_t HOME_Y = coord_t'(`ROUTER_Y);

	// Productive directions indexed by absolute port code
	logic [4:0] want;

	// Minimal adaptive routing keeps both axes open while both offsets are non-zero
	always_comb
	begin
		want = '0;
		if (flit_valid)
		begin
			want[`X_POS] = flit.dest_x > HOME_X;
			want[`X_NEG] = flit.dest_x < HOME_X;
			want[`Y_POS] = flit.dest_y > HOME_Y;
			want[`Y_NEG] = flit.dest_y < HOME_Y;
			// Local delivery only once the flit has arrived on both axes
			want[`PE]    = (flit.dest_x == HOME_X) && (flit.dest_y == HOME_Y);
		end
	end

	// Fold the absolute directions into this input's relative request bits
	always_comb
	begin
		request = '0;
		case (PORT_DIR)
			`PE:
			begin
				request[`PE_XPOS] = want[`X_POS];
				request[`PE_YPOS] = want[`Y_POS];
				request[`PE_XNEG] = want[`X_NEG];
				request[`PE_YNEG] = want[`Y_NEG];
			end
			`X_POS:
			begin
				request[`XPOS_PE]   = want[`PE];
				request[`XPOS_YPOS] = want[`Y_POS];
				request[`XPOS_XNEG] = want[`X_NEG];
				request[`XPOS_YNEG] = want[`Y_NEG];
			end
			`Y_POS:
			begin
				request[`YPOS_PE]   = want[`PE];
				request[`YPOS_XPOS] = want[`X_POS];
				request[`YPOS_XNEG] = want[`X_NEG];
				request[`YPOS_YNEG] = want[`Y_NEG];
			end
			`X_NEG:
			begin
				request[`XNEG_PE]   = want[`PE];
				request[`XNEG_XPOS] = want[`X_POS];
				request[`XNEG_YPOS] = want[`Y_POS];
				request[`XNEG_YNEG] = want[`Y_NEG];
			end
			default:
			begin
				request[`YNEG_PE]   = want[`PE];
				request[`YNEG_XPOS] = want[`X_POS];
				request[`YNEG_YPOS] = want[`Y_POS];
				request[`YNEG_XNEG] = want[`X_NEG];
			end
		endcase
	end

	// A flit heading back out of the port it came in on means the sender misrouted it
	always_comb
	begin
		no_u_turn : assert (!want[PORT_DIR])
		else $error("route_planner %0d: flit wants its own input direction", PORT_DIR);
	end

endmodule

`default_nettype wire

/* design/router_core.sv */
`timescale 1ns/1ps
`default_nettype none

module router_core
	import noc_flit_pkg::*, noc_port_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  link_in_t  in [5],
	output logic      in_ready [5],
	output link_out_t out [5],
	input  logic      out_ready [5]
);

	logic     buf_valid [5];
	flit_t    buf_flit  [5];
	logic     strobe    [5];
	req_vec_t raw_req   [5];
	req_vec_t status    [5];
	req_vec_t sel_req   [5];
	req_vec_t arb_req   [5];
	req_vec_t grant     [5];
	req_vec_t grant_to  [5];
	logic     free      [5];
	flit_t    xbar_flit [5];

	for (genvar p = 0; p < 5; p++)
	begin : g_lane
		// Input buffer, emptied by the transfer strobe of its own grant
		flit_register #(.payload_t(flit_t)) u_in_buf (
			.clk       (clk),
			.reset     (reset),
			.in_valid  (in[p].valid),
			.in_data   (in[p].flit),
			.in_ready  (in_ready[p]),
			.out_valid (buf_valid[p]),
			.out_data  (buf_flit[p]),
			.out_ready (strobe[p])
		);

		route_planner #(.PORT_DIR(port_dir_t'(p))) u_planner (
			.flit_valid (buf_valid[p]),
			.flit       (buf_flit[p]),
			.request    (raw_req[p])
		);

		selector #(.PORT_DIR(port_dir_t'(p))) u_selector (
			.request         (raw_req[p]),
			.transfer_strobe (strobe[p]),
			.status          (status[p]),
			.masked_request  (sel_req[p])
		);

		output_arbiter #(.OUT_DIR(port_dir_t'(p))) u_arbiter (
			.clk       (clk),
			.reset     (reset),
			.request   (arb_req[p]),
			.grant     (grant[p]),
			.flit_in   (xbar_flit[p]),
			.out       (out[p]),
			.out_ready (out_ready[p]),
			.free      (free[p])
		);

		// Relative bit r of port p names port OTHER
		// BACK is the bit that names p again from OTHER's side
		for (genvar r = 0; r < 4; r++)
		begin : g_rel
			localparam int OTHER = (r < p) ? r : r + 1;
			localparam int BACK  = (p < OTHER) ? p : p - 1;

			// Port p as an output collects the request of input OTHER
			assign arb_req[p][r]  = sel_req[OTHER][BACK];
			// Port p as an input sees whether output OTHER is free
			assign status[p][r]   = free[OTHER];
			// Port p as an input sees the grant that output OTHER holds for it
			assign grant_to[p][r] = grant[OTHER][BACK];
		end

		assign strobe[p] = grant_to[p] != '0;
	end

	// Crossbar, each output ORs in the buffered flit of whichever input it granted
	always_comb
	begin
		for (int o = 0; o < 5; o++)
		begin
			xbar_flit[o] = '0;
			for (int r = 0; r < 4; r++)
			begin
				xbar_flit[o] = xbar_flit[o]
					| ({$bits(flit_t){grant[o][r]}} & buf_flit[(r < o) ? r : r + 1]);
			end
		end
	end

endmodule

`default_nettype wire

/* design/selector.sv */
`timescale 1ns/1ps
`default_nettype none

module selector
	import noc_port_pkg::*;
#(
	parameter port_dir_t PORT_DIR = DIR_XPOS
)
(
	input  req_vec_t request,
	input  logic     transfer_strobe,
	input  req_vec_t status,
	output req_vec_t masked_request
);

	req_vec_t open_request;

	// Nothing leaves while this input's flit is being moved
	// Otherwise only outputs that report free stay in the running
	assign open_request = transfer_strobe ? '0 : (request & status);

	// Relative numbering keeps the global order PE, X+, Y+, X-, Y- without the own direction
	// So relative bit 0 always has the highest priority
	// Walk from the lowest priority upward so the best candidate is written last
	always_comb
	begin
		masked_request = '0;
		for (int k = 3; k >= 0; k--)
		begin
			if (open_request[k])
			begin
				masked_request    = '0;
				masked_request[k] = 1'b1;
			end
		end
	end

	// At most one arbiter may see this flit at a time
	always_comb
	begin
		single_request : assert ($onehot0(masked_request))
		else $error("selector %0d: request %b is not one-hot", PORT_DIR, masked_request);
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/noc_flit_pkg.sv
design/noc_port_pkg.sv
design/flit_register.sv
design/route_planner.sv
design/selector.sv
design/output_arbiter.sv
design/router_core.sv
verif/router_core_tb.sv

/* verif/router_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module router_core_tb
	import noc_flit_pkg::*, noc_port_pkg::*;
();

	localparam int MAX_FLITS = 64;
	localparam int COLS      = 8;
	localparam int PERIOD_NS = 4;

	logic      clk;
	logic      reset;
	link_in_t  in_link   [5];
	logic      in_ready  [5];
	link_out_t out_link  [5];
	logic      out_ready [5];

	// Raw words of the stimulus file, a flit count first and then eight words per flit
	logic [31:0] stim_words [0:MAX_FLITS*COLS];

	int         n_flits;
	int         last_cycle;
	bit         loaded;
	int         cycle;
	int         seed;
	int         errors;
	int         accepted_count;
	int         delivered_count;
	logic [5:0] ready_mask;

	// What the file says about each flit
	int         st_cycle   [MAX_FLITS];
	int         st_port    [MAX_FLITS];
	flit_t      st_flit    [MAX_FLITS];
	logic [5:0] st_mask    [MAX_FLITS];
	int         st_exp_out [MAX_FLITS];
	int         st_exp_lat [MAX_FLITS];

	// Scoreboard, filled in as the router takes and hands out flits
	int accept_edge [MAX_FLITS];
	int seq         [MAX_FLITS];
	bit seen        [MAX_FLITS];
	bit delivered   [MAX_FLITS];
	int entry_of    [int];

	// Per port bookkeeping for the drivers and the output monitors
	int    head         [5];
	bit    taken        [5];
	int    accepted_seq [5];
	int    last_seq_out [5];
	bit    hold         [5];
	flit_t held_flit    [5];

	router_core uut (
		.clk       (clk),
		.reset     (reset),
		.in        (in_link),
		.in_ready  (in_ready),
		.out       (out_link),
		.out_ready (out_ready)
	);

	always #2 clk = ~clk;

	// Next file entry at or after from that enters on the given port
	function automatic int next_for_port(input int port, input int from);
		int e;
		e = from;
		while (e < n_flits && st_port[e] != port)
			e++;
		return e;
	endfunction

	// Minimal routing, an output is productive when it shrinks an offset
	// PE counts only once both offsets are gone
	function automatic bit productive(input int port, input flit_t f);
		case (port)
			`PE:     return (f.dest_x == `ROUTER_X) && (f.dest_y == `ROUTER_Y);
			`X_POS:  return f.dest_x > `ROUTER_X;
			`Y_POS:  return f.dest_y > `ROUTER_Y;
			`X_NEG:  return f.dest_x < `ROUTER_X;
			default: return f.dest_y < `ROUTER_Y;
		endcase
	endfunction

	task automatic load_stimulus();
		int base;
		$readmemh("verif/router_stimulus.txt", stim_words);
		n_flits    = stim_words[0];
		last_cycle = 0;
		assert (n_flits <= MAX_FLITS)
		else
		begin
			errors++;
			$display("Stimulus file lists %0d flits, more than the testbench holds", n_flits);
		end
		if (n_flits > MAX_FLITS)
			n_flits = MAX_FLITS;
		for (int e = 0; e < n_flits; e++)
		begin
			base                  = 1 + e * COLS;
			st_cycle[e]           = stim_words[base];
			st_port[e]            = stim_words[base + 1];
			st_flit[e].dest_x     = coord_t'(stim_words[base + 2]);
			st_flit[e].dest_y     = coord_t'(stim_words[base + 3]);
			st_flit[e].payload    = stim_words[base + 4][`PAYLOAD_W-1:0];
			st_mask[e]            = stim_words[base + 5][5:0];
			st_exp_out[e]         = stim_words[base + 6];
			st_exp_lat[e]         = stim_words[base + 7];
			if (st_cycle[e] > last_cycle)
				last_cycle = st_cycle[e];
		end
		for (int p = 0; p < 5; p++)
		begin
			head[p]         = next_for_port(p, 0);
			last_seq_out[p] = -1;
		end
		loaded = 1'b1;
	endtask

	// The flit on in[p] goes into the input buffer on the coming edge
	task automatic record_accept(input int p);
		int e;
		e = head[p];
		assert (!entry_of.exists(int'(in_link[p].flit.payload)))
		else
		begin
			errors++;
			$display("Payload %h was accepted a second time", in_link[p].flit.payload);
		end
		entry_of[int'(in_link[p].flit.payload)] = e;
		accept_edge[e] = cycle + 1;
		seq[e]         = accepted_seq[p];
		accepted_seq[p]++;
		accepted_count++;
	endtask

	// First sight of a flit on an output is the cycle its out valid rose
	task automatic check_departure(input int o, input int e, input flit_t f);
		seen[e] = 1'b1;
		assert (productive(o, f))
		else
		begin
			errors++;
			$display("CHECK FAILED out[%0d].flit dest %h,%h is not productive", o, f.dest_x, f.dest_y);
		end
		assert (f == st_flit[e])
		else
		begin
			errors++;
			$display("CHECK FAILED out[%0d].flit got %h, expected %h", o, f, st_flit[e]);
		end
		if (st_exp_out[e] != 7)
		begin
			assert (o == st_exp_out[e])
			else
			begin
				errors++;
				$display("CHECK FAILED output of payload %h got %h, expected %h",
					f.payload, o, st_exp_out[e]);
			end
		end
		if (st_exp_lat[e] != 0)
		begin
			assert (cycle - accept_edge[e] == st_exp_lat[e])
			else
			begin
				errors++;
				$display("CHECK FAILED out[%0d].valid latency got %h, expected %h",
					o, cycle - accept_edge[e], st_exp_lat[e]);
			end
		end
		// The input buffer holds one flit, so each input empties strictly in order
		assert (seq[e] == last_seq_out[st_port[e]] + 1)
		else
		begin
			errors++;
			$display("Payload %h left input %0d out of its acceptance order", f.payload, st_port[e]);
		end
		last_seq_out[st_port[e]] = seq[e];
	endtask

	task automatic watch_output(input int o);
		int    e;
		bit    known;
		flit_t f;
		f = out_link[o].flit;
		// A flit that was refused on the last edge must still be there, untouched
		if (hold[o])
		begin
			assert (out_link[o].valid && f == held_flit[o])
			else
			begin
				errors++;
				$display("CHECK FAILED out[%0d].flit held %h, now %h with valid %h",
					o, held_flit[o], f, out_link[o].valid);
			end
		end
		hold[o]      = out_link[o].valid && !out_ready[o];
		held_flit[o] = f;
		if (out_link[o].valid)
		begin
			known = entry_of.exists(int'(f.payload));
			assert (known)
			else
			begin
				errors++;
				$display("Output %0d carries payload %h that no input accepted", o, f.payload);
			end
			if (known)
			begin
				e = entry_of[int'(f.payload)];
				if (!seen[e])
					check_departure(o, e, f);
				if (out_ready[o])
				begin
					assert (!delivered[e])
					else
					begin
						errors++;
						$display("Payload %h was delivered a second time", f.payload);
					end
					if (!delivered[e])
						delivered_count++;
					delivered[e] = 1'b1;
				end
			end
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d, accepted: %0d, delivered: %0d of %0d",
			errors, accepted_count, delivered_count, n_flits);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	// Inputs change only right after a rising edge
	always @(posedge clk)
	begin
		logic [31:0] rnd;
		cycle = cycle + 1;
		for (int e = 0; e < n_flits; e++)
		begin
			if (st_cycle[e] == cycle)
				ready_mask = st_mask[e];
		end
		// Bit 5 of the mask lets the random bits stall the enabled outputs
		rnd = $random(seed);
		for (int o = 0; o < 5; o++)
			out_ready[o] <= ready_mask[o] && (!ready_mask[5] || rnd[o]);
		for (int p = 0; p < 5; p++)
		begin
			if (taken[p])
				head[p] = next_for_port(p, head[p] + 1);
			if (head[p] < n_flits && st_cycle[head[p]] <= cycle)
			begin
				in_link[p].valid <= 1'b1;
				in_link[p].flit  <= st_flit[head[p]];
			end
			else
				in_link[p].valid <= 1'b0;
		end
	end

	// Everything is sampled mid cycle, where inputs and outputs have settled
	always @(negedge clk)
	begin
		for (int p = 0; p < 5; p++)
		begin
			taken[p] = in_link[p].valid && in_ready[p];
			if (taken[p])
				record_accept(p);
		end
		for (int o = 0; o < 5; o++)
			watch_output(o);
		// First cycle out of reset, nothing has been offered yet
		if (cycle == 9)
		begin
			for (int p = 0; p < 5; p++)
			begin
				assert (!out_link[p].valid && in_ready[p])
				else
				begin
					errors++;
					$display("CHECK FAILED after reset out[%0d].valid %h, in_ready[%0d] %h",
						p, out_link[p].valid, p, in_ready[p]);
				end
			end
		end
	end

	initial
	begin
		clk             = 1'b0;
		reset           = 1'b1;
		seed            = 32'h34ee;
		cycle           = 0;
		errors          = 0;
		accepted_count  = 0;
		delivered_count = 0;
		ready_mask      = 6'h1f;
		for (int p = 0; p < 5; p++)
		begin
			in_link[p]   = '0;
			out_ready[p] = 1'b1;
		end
		load_stimulus();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		while (delivered_count < n_flits || cycle <= last_cycle)
			@(posedge clk);
		// A few idle cycles so that a stray extra flit would still show up
		repeat (4) @(posedge clk);
		for (int e = 0; e < n_flits; e++)
		begin
			assert (delivered[e])
			else
			begin
				errors++;
				$display("Payload %h from input %0d never left the router",
					st_flit[e].payload, st_port[e]);
			end
		end
		finish_run();
	end

	// Watchdog sized from the last stimulus cycle plus a drain allowance
	initial
	begin
		wait (loaded);
		#((last_cycle + 200) * PERIOD_NS);
		errors++;
		$display("Timeout: the router did not deliver every flit in time");
		finish_run();
	end

endmodule

`default_nettype wire

/* verif/router_stimulus.txt */
// cycle port dest_x dest_y payload ready_mask exp_out exp_lat, all hex, first word is the flit count
// ready_mask bit 5 turns on random stalls, exp_out 7 and exp_lat 0 leave that value unchecked
16
10 0 5 6 1001 1f 1 2
14 3 6 1 1002 1f 1 2
20 0 4 3 2001 1d 1 2
28 4 5 6 2002 1d 2 2
30 0 3 5 3001 19 2 2
34 3 5 5 3002 19 1 0
40 0 1 3 4001 1f 3 2
50 1 3 3 5001 1f 0 0
50 2 3 3 5002 1f 0 0
50 3 3 3 5003 1f 0 0
50 4 3 3 5004 1f 0 0
50 1 3 3 5011 1f 0 0
50 3 3 3 5012 1f 0 0
70 0 0 0 7001 3f 7 0
70 1 2 5 7002 3f 7 0
70 2 5 1 7003 3f 7 0
70 3 3 0 7004 3f 4 0
70 4 0 3 7005 3f 3 0
70 0 6 6 7006 3f 7 0
70 2 3 3 7007 3f 0 0
70 1 3 3 7008 3f 0 0
90 4 3 7 9001 1f 2 0
